/* hw/mips_pkg.sv */
`default_nettype none

package mips_pkg;

	// datapath widths
	localparam int WORD_W     = 32;
	localparam int REG_ADDR_W = 5;
	localparam int ALU_OP_W   = 3;
	localparam int STATE_W    = 9;

	// alu operation codes
	localparam logic [ALU_OP_W-1:0] ALU_AND  = 3'b000;
	localparam logic [ALU_OP_W-1:0] ALU_OR   = 3'b001;
	localparam logic [ALU_OP_W-1:0] ALU_ADD  = 3'b010;
	localparam logic [ALU_OP_W-1:0] ALU_SLTU = 3'b011;
	localparam logic [ALU_OP_W-1:0] ALU_XOR  = 3'b100;
	localparam logic [ALU_OP_W-1:0] ALU_NOR  = 3'b101;
	localparam logic [ALU_OP_W-1:0] ALU_SUB  = 3'b110;
	localparam logic [ALU_OP_W-1:0] ALU_SLT  = 3'b111;

	// one-hot states, bit 0 is reset
	localparam logic [STATE_W-1:0] S_RST = 9'b000000001;
	localparam logic [STATE_W-1:0] S_IF  = 9'b000000010;
	localparam logic [STATE_W-1:0] S_IW  = 9'b000000100;
	localparam logic [STATE_W-1:0] S_ID  = 9'b000001000;
	localparam logic [STATE_W-1:0] S_EX  = 9'b000010000;
	localparam logic [STATE_W-1:0] S_LD  = 9'b000100000;
	localparam logic [STATE_W-1:0] S_ST  = 9'b001000000;
	localparam logic [STATE_W-1:0] S_RDW = 9'b010000000;
	localparam logic [STATE_W-1:0] S_WB  = 9'b100000000;

	// opcodes
	localparam logic [5:0] OP_RTYPE = 6'b000000;
	localparam logic [5:0] OP_J     = 6'b000010;
	localparam logic [5:0] OP_BEQ   = 6'b000100;
	localparam logic [5:0] OP_BNE   = 6'b000101;
	localparam logic [5:0] OP_ADDIU = 6'b001001;
	localparam logic [5:0] OP_SLTI  = 6'b001010;
	localparam logic [5:0] OP_SLTIU = 6'b001011;
	localparam logic [5:0] OP_ANDI  = 6'b001100;
	localparam logic [5:0] OP_ORI   = 6'b001101;
	localparam logic [5:0] OP_XORI  = 6'b001110;
	localparam logic [5:0] OP_LUI   = 6'b001111;
	localparam logic [5:0] OP_LW    = 6'b100011;
	localparam logic [5:0] OP_SW    = 6'b101011;

	// r-type funct codes
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_NOR  = 6'b100111;
	localparam logic [5:0] FN_SLT  = 6'b101010;
	localparam logic [5:0] FN_SLTU = 6'b101011;

	// one instruction word seen as r, i or j format
	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0]  opcode;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] imm;
		} i;
		struct packed {
			logic [5:0]  opcode;
			logic [25:0] index;
		} j;
	} instr_u;

endpackage

`default_nettype wire

/* hw/mips_alu.sv */
`default_nettype none

module mips_alu (
	input  wire [mips_pkg::WORD_W-1:0]   a,
	input  wire [mips_pkg::WORD_W-1:0]   b,
	input  wire [mips_pkg::ALU_OP_W-1:0] alu_op,
	output logic [mips_pkg::WORD_W-1:0]  result,
	output logic                         zero
);

	// separate adder and subtractor
	logic [mips_pkg::WORD_W-1:0] sum;
	logic [mips_pkg::WORD_W-1:0] diff;

	assign sum  = a + b;
	assign diff = a - b;

	always_comb begin
		case (alu_op)
			mips_pkg::ALU_AND:  result = a & b;
			mips_pkg::ALU_OR:   result = a | b;
			mips_pkg::ALU_ADD:  result = sum;
			mips_pkg::ALU_XOR:  result = a ^ b;
			mips_pkg::ALU_NOR:  result = ~(a | b);
			mips_pkg::ALU_SUB:  result = diff;
			// set-less-than results only use bit 0
			mips_pkg::ALU_SLTU: result = {{(mips_pkg::WORD_W-1){1'b0}}, a < b};
			mips_pkg::ALU_SLT:  result = {{(mips_pkg::WORD_W-1){1'b0}}, $signed(a) < $signed(b)};
			default:            result = sum;
		endcase
	end

	// branch compare uses subtract and tests this flag
	assign zero = (result == '0);

endmodule

`default_nettype wire

/* hw/reg_file.sv */
`default_nettype none

module reg_file (
	input  wire                             clk,
	input  wire [mips_pkg::REG_ADDR_W-1:0]  raddr1,
	input  wire [mips_pkg::REG_ADDR_W-1:0]  raddr2,
	output logic [mips_pkg::WORD_W-1:0]     rdata1,
	output logic [mips_pkg::WORD_W-1:0]     rdata2,
	input  wire                             wen,
	input  wire [mips_pkg::REG_ADDR_W-1:0]  waddr,
	input  wire [mips_pkg::WORD_W-1:0]      wdata
);

	logic [mips_pkg::WORD_W-1:0] regs [32];

	// write port, register zero never stored
	always_ff @(posedge clk) begin
		if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// asynchronous reads, zero forced on address 0
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* hw/inst_decoder.sv */
`default_nettype none

module inst_decoder (
	input  wire mips_pkg::instr_u           instr,
	output logic [mips_pkg::ALU_OP_W-1:0]   alu_op,
	output logic                            use_imm,
	output logic                            zero_ext,
	output logic                            is_lui,
	output logic                            writes_reg,
	output logic [mips_pkg::REG_ADDR_W-1:0] waddr,
	output logic                            is_load,
	output logic                            is_store,
	output logic                            is_beq,
	output logic                            is_bne,
	output logic                            is_jump,
	output logic                            is_nop
);

	// opcode or funct outside the supported set
	logic illegal;
	// class before the illegal marker is merged in
	logic load_op;
	logic store_op;

	always_comb begin
		alu_op     = mips_pkg::ALU_ADD;
		use_imm    = 1'b0;
		zero_ext   = 1'b0;
		is_lui     = 1'b0;
		writes_reg = 1'b0;
		waddr      = instr.i.rt;
		load_op    = 1'b0;
		store_op   = 1'b0;
		is_beq     = 1'b0;
		is_bne     = 1'b0;
		is_jump    = 1'b0;
		is_nop     = 1'b0;
		illegal    = 1'b0;
		case (instr.r.opcode)
			mips_pkg::OP_RTYPE: begin
				waddr = instr.r.rd;
				case (instr.r.funct)
					mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
					mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
					mips_pkg::FN_AND:  alu_op = mips_pkg::ALU_AND;
					mips_pkg::FN_OR:   alu_op = mips_pkg::ALU_OR;
					mips_pkg::FN_XOR:  alu_op = mips_pkg::ALU_XOR;
					mips_pkg::FN_NOR:  alu_op = mips_pkg::ALU_NOR;
					mips_pkg::FN_SLT:  alu_op = mips_pkg::ALU_SLT;
					mips_pkg::FN_SLTU: alu_op = mips_pkg::ALU_SLTU;
					default:           illegal = 1'b1;
				endcase
				// all-zero word is the nop, not a shift
				if (instr == '0) begin
					is_nop  = 1'b1;
					illegal = 1'b0;
				end
				writes_reg = ~illegal & ~is_nop;
			end
			mips_pkg::OP_J: is_jump = 1'b1;
			// branches compare rs and rt by subtract
			mips_pkg::OP_BEQ: begin
				alu_op = mips_pkg::ALU_SUB;
				is_beq = 1'b1;
			end
			mips_pkg::OP_BNE: begin
				alu_op = mips_pkg::ALU_SUB;
				is_bne = 1'b1;
			end
			mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU: begin
				use_imm    = 1'b1;
				writes_reg = 1'b1;
				if (instr.i.opcode == mips_pkg::OP_SLTI) begin
					alu_op = mips_pkg::ALU_SLT;
				end else if (instr.i.opcode == mips_pkg::OP_SLTIU) begin
					alu_op = mips_pkg::ALU_SLTU;
				end
			end
			// logical immediates are zero extended
			mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI: begin
				use_imm    = 1'b1;
				zero_ext   = 1'b1;
				writes_reg = 1'b1;
				if (instr.i.opcode == mips_pkg::OP_ANDI) begin
					alu_op = mips_pkg::ALU_AND;
				end else if (instr.i.opcode == mips_pkg::OP_ORI) begin
					alu_op = mips_pkg::ALU_OR;
				end else begin
					alu_op = mips_pkg::ALU_XOR;
				end
			end
			mips_pkg::OP_LUI: begin
				use_imm    = 1'b1;
				is_lui     = 1'b1;
				writes_reg = 1'b1;
			end
			// address is base plus sign-extended offset
			mips_pkg::OP_LW: begin
				use_imm    = 1'b1;
				load_op    = 1'b1;
				writes_reg = 1'b1;
			end
			mips_pkg::OP_SW: begin
				use_imm  = 1'b1;
				store_op = 1'b1;
			end
			default: illegal = 1'b1;
		endcase
	end

	// load and store together mark an illegal word for the FSM
	assign is_load  = load_op | illegal;
	assign is_store = store_op | illegal;

endmodule

`default_nettype wire

/* hw/multicycle_fsm.sv */
`default_nettype none

module multicycle_fsm (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          inst_req_ready,
	input  wire                          inst_valid,
	input  wire                          mem_req_ready,
	input  wire                          read_data_valid,
	input  wire                          is_nop,
	input  wire                          is_load,
	input  wire                          is_store,
	input  wire                          writes_reg,
	output logic [mips_pkg::STATE_W-1:0] state,
	output logic                         inst_req_valid,
	output logic                         inst_ready,
	output logic                         mem_read,
	output logic                         mem_write,
	output logic                         read_data_ready
);

	logic [mips_pkg::STATE_W-1:0] next_state;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= mips_pkg::S_RST;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		case (state)
			mips_pkg::S_RST: next_state = mips_pkg::S_IF;
			// hold until the request is taken
			mips_pkg::S_IF:
				next_state = inst_req_ready ? mips_pkg::S_IW : mips_pkg::S_IF;
			mips_pkg::S_IW:
				next_state = inst_valid ? mips_pkg::S_ID : mips_pkg::S_IW;
			// nop skips execute entirely
			mips_pkg::S_ID:
				next_state = is_nop ? mips_pkg::S_IF : mips_pkg::S_EX;
			mips_pkg::S_EX: begin
				if (is_load && is_store) begin
					next_state = mips_pkg::S_RST;
				end else if (is_load) begin
					next_state = mips_pkg::S_LD;
				end else if (is_store) begin
					next_state = mips_pkg::S_ST;
				end else if (writes_reg) begin
					next_state = mips_pkg::S_WB;
				end else begin
					// branch or jump, pc already updated
					next_state = mips_pkg::S_IF;
				end
			end
			mips_pkg::S_LD:
				next_state = mem_req_ready ? mips_pkg::S_RDW : mips_pkg::S_LD;
			mips_pkg::S_ST:
				next_state = mem_req_ready ? mips_pkg::S_IF : mips_pkg::S_ST;
			mips_pkg::S_RDW:
				next_state = read_data_valid ? mips_pkg::S_WB : mips_pkg::S_RDW;
			mips_pkg::S_WB: next_state = mips_pkg::S_IF;
			default: next_state = mips_pkg::S_RST;
		endcase
	end

	// channel strobes straight from state bits
	assign inst_req_valid  = |(state & mips_pkg::S_IF);
	assign inst_ready      = |(state & mips_pkg::S_IW);
	assign mem_read        = |(state & mips_pkg::S_LD);
	assign mem_write       = |(state & mips_pkg::S_ST);
	assign read_data_ready = |(state & mips_pkg::S_RDW);

endmodule

`default_nettype wire

/* hw/mips_cpu.sv */
`default_nettype none

module mips_cpu (
	input  wire                             clk,
	input  wire                             rst,
	output logic [mips_pkg::WORD_W-1:0]     pc,
	output logic                            inst_req_valid,
	input  wire                             inst_req_ready,
	input  wire [mips_pkg::WORD_W-1:0]      instruction,
	input  wire                             inst_valid,
	output logic                            inst_ready,
	output logic [mips_pkg::WORD_W-1:0]     address,
	output logic                            mem_read,
	output logic                            mem_write,
	output logic [mips_pkg::WORD_W-1:0]     write_data,
	input  wire                             mem_req_ready,
	input  wire [mips_pkg::WORD_W-1:0]      read_data,
	input  wire                             read_data_valid,
	output logic                            read_data_ready,
	output logic                            rf_wen,
	output logic [mips_pkg::REG_ADDR_W-1:0] rf_waddr,
	output logic [mips_pkg::WORD_W-1:0]     rf_wdata,
	output logic [mips_pkg::WORD_W-1:0]     retire_pc
);

	logic [mips_pkg::STATE_W-1:0]  state;
	logic                          st_if;
	logic                          st_iw;
	logic                          st_id;
	logic                          st_ex;

	// latches and operand registers
	mips_pkg::instr_u              instr_q;
	logic [mips_pkg::WORD_W-1:0]   rdata_q;
	logic [mips_pkg::WORD_W-1:0]   op_a;
	logic [mips_pkg::WORD_W-1:0]   op_b;
	logic [mips_pkg::ALU_OP_W-1:0] alu_op_q;
	logic [mips_pkg::WORD_W-1:0]   alu_out;

	// decoder outputs
	logic [mips_pkg::ALU_OP_W-1:0] dec_alu_op;
	logic                          use_imm;
	logic                          zero_ext;
	logic                          is_lui;
	logic                          writes_reg;
	logic                          is_load;
	logic                          is_store;
	logic                          is_beq;
	logic                          is_bne;
	logic                          is_jump;
	logic                          is_nop;

	logic [mips_pkg::WORD_W-1:0]   rdata1;
	logic [mips_pkg::WORD_W-1:0]   rdata2;
	logic [mips_pkg::WORD_W-1:0]   imm_ext;
	logic [mips_pkg::WORD_W-1:0]   alu_a;
	logic [mips_pkg::WORD_W-1:0]   alu_b;
	logic [mips_pkg::ALU_OP_W-1:0] alu_sel;
	logic [mips_pkg::WORD_W-1:0]   alu_result;
	logic                          alu_zero;
	logic                          br_taken;
	logic [mips_pkg::WORD_W-1:0]   br_target;
	logic [mips_pkg::WORD_W-1:0]   j_target;

	multicycle_fsm multicycle_fsm_inst (
		.clk             (clk),
		.rst             (rst),
		.inst_req_ready  (inst_req_ready),
		.inst_valid      (inst_valid),
		.mem_req_ready   (mem_req_ready),
		.read_data_valid (read_data_valid),
		.is_nop          (is_nop),
		.is_load         (is_load),
		.is_store        (is_store),
		.writes_reg      (writes_reg),
		.state           (state),
		.inst_req_valid  (inst_req_valid),
		.inst_ready      (inst_ready),
		.mem_read        (mem_read),
		.mem_write       (mem_write),
		.read_data_ready (read_data_ready)
	);

	assign st_if = |(state & mips_pkg::S_IF);
	assign st_iw = |(state & mips_pkg::S_IW);
	assign st_id = |(state & mips_pkg::S_ID);
	assign st_ex = |(state & mips_pkg::S_EX);

	inst_decoder inst_decoder_inst (
		.instr      (instr_q),
		.alu_op     (dec_alu_op),
		.use_imm    (use_imm),
		.zero_ext   (zero_ext),
		.is_lui     (is_lui),
		.writes_reg (writes_reg),
		.waddr      (rf_waddr),
		.is_load    (is_load),
		.is_store   (is_store),
		.is_beq     (is_beq),
		.is_bne     (is_bne),
		.is_jump    (is_jump),
		.is_nop     (is_nop)
	);

	reg_file reg_file_inst (
		.clk    (clk),
		.raddr1 (instr_q.r.rs),
		.raddr2 (instr_q.r.rt),
		.rdata1 (rdata1),
		.rdata2 (rdata2),
		.wen    (rf_wen),
		.waddr  (rf_waddr),
		.wdata  (rf_wdata)
	);

	// capture on each handshake
	always_ff @(posedge clk) begin
		if (inst_ready && inst_valid) begin
			instr_q <= instruction;
		end
		if (read_data_ready && read_data_valid) begin
			rdata_q <= read_data;
		end
	end

	// immediate, zero or sign extended
	assign imm_ext = {{(mips_pkg::WORD_W-16){instr_q.i.imm[15] & ~zero_ext}}, instr_q.i.imm};

	// operands loaded in decode, result in execute
	always_ff @(posedge clk) begin
		if (st_id) begin
			op_a     <= rdata1;
			op_b     <= use_imm ? imm_ext : rdata2;
			alu_op_q <= dec_alu_op;
		end
		if (st_ex) begin
			alu_out <= alu_result;
		end
	end

	// fetch-wait borrows the alu for pc+4
	assign alu_a   = st_iw ? pc : op_a;
	assign alu_b   = st_iw ? mips_pkg::WORD_W'(4) : op_b;
	assign alu_sel = st_iw ? mips_pkg::ALU_ADD : alu_op_q;

	mips_alu mips_alu_inst (
		.a      (alu_a),
		.b      (alu_b),
		.alu_op (alu_sel),
		.result (alu_result),
		.zero   (alu_zero)
	);

	// pc already holds pc+4 by execute
	assign br_taken  = (is_beq & alu_zero) | (is_bne & ~alu_zero);
	assign br_target = pc + {{(mips_pkg::WORD_W-18){instr_q.i.imm[15]}}, instr_q.i.imm, 2'b00};
	assign j_target  = {pc[mips_pkg::WORD_W-1:mips_pkg::WORD_W-4], instr_q.j.index, 2'b00};

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else if (st_iw && inst_valid) begin
			pc <= alu_result;
		end else if (st_ex && br_taken) begin
			pc <= br_target;
		end else if (st_ex && is_jump) begin
			pc <= j_target;
		end
	end

	// pc of the instruction now being fetched
	always_ff @(posedge clk) begin
		if (rst) begin
			retire_pc <= '0;
		end else if (st_if) begin
			retire_pc <= pc;
		end
	end

	// word-aligned data access, rt is the store data
	assign address    = {alu_out[mips_pkg::WORD_W-1:2], 2'b00};
	assign write_data = rdata2;

	// write-back select
	assign rf_wen   = |(state & mips_pkg::S_WB);
	assign rf_wdata = is_lui ? {instr_q.i.imm, {(mips_pkg::WORD_W-16){1'b0}}} :
	                  is_load ? rdata_q : alu_out;

endmodule

`default_nettype wire

/* include/tb_mips_model.svh */
`ifndef TB_MIPS_MODEL_SVH
`define TB_MIPS_MODEL_SVH

// random kept instruction for slot idx of an n_words program
// draws from the testbench seed
function automatic logic [31:0] gen_instr(input int idx, input int n_words);
	mips_pkg::instr_u ins;
	int target;
	int offset;
	ins    = $random(seed);
	target = {$random(seed)} % n_words;
	// branch offsets land inside the program
	offset = target - idx - 1;
	case ({$random(seed)} % 16)
		0, 1, 2: begin
			ins.r.opcode = mips_pkg::OP_RTYPE;
			ins.r.shamt  = '0;
			case ({$random(seed)} % 8)
				0: ins.r.funct = mips_pkg::FN_ADDU;
				1: ins.r.funct = mips_pkg::FN_SUBU;
				2: ins.r.funct = mips_pkg::FN_AND;
				3: ins.r.funct = mips_pkg::FN_OR;
				4: ins.r.funct = mips_pkg::FN_XOR;
				5: ins.r.funct = mips_pkg::FN_NOR;
				6: ins.r.funct = mips_pkg::FN_SLT;
				default: ins.r.funct = mips_pkg::FN_SLTU;
			endcase
		end
		3: ins.i.opcode = mips_pkg::OP_ADDIU;
		4: ins.i.opcode = mips_pkg::OP_SLTI;
		5: ins.i.opcode = mips_pkg::OP_SLTIU;
		6: ins.i.opcode = mips_pkg::OP_ANDI;
		7: ins.i.opcode = mips_pkg::OP_ORI;
		8: ins.i.opcode = mips_pkg::OP_XORI;
		9: ins.i.opcode = mips_pkg::OP_LUI;
		// base register zero keeps the address aligned
		10, 11: begin
			ins.i.opcode = (ins.i.rt[0]) ? mips_pkg::OP_LW : mips_pkg::OP_SW;
			ins.i.rs     = '0;
			ins.i.imm    = 16'(({$random(seed)} % 16) * 4);
		end
		12, 13: begin
			ins.i.opcode = (ins.i.rt[1]) ? mips_pkg::OP_BEQ : mips_pkg::OP_BNE;
			ins.i.imm    = 16'(offset);
		end
		14: begin
			ins.j.opcode = mips_pkg::OP_J;
			ins.j.index  = 26'(target);
		end
		default: ins = '0;
	endcase
	return ins;
endfunction

// one instruction at the isa level, pc advances to the next fetch
function automatic void model_step(
	ref logic [31:0] regs [32],
	ref logic [31:0] dmem [16],
	input logic [31:0] word,
	ref logic [31:0] pc,
	output bit wb_en,
	output logic [4:0] wb_addr,
	output logic [31:0] wb_data,
	output bit st_en,
	output logic [31:0] st_addr,
	output logic [31:0] st_data
);
	mips_pkg::instr_u ins;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] sx;
	logic [31:0] zx;
	logic [31:0] pc4;
	logic [31:0] ea;
	ins     = word;
	a       = regs[ins.r.rs];
	b       = regs[ins.r.rt];
	sx      = {{16{ins.i.imm[15]}}, ins.i.imm};
	zx      = {16'b0, ins.i.imm};
	pc4     = pc + 32'd4;
	ea      = a + sx;
	wb_en   = 1'b1;
	wb_addr = ins.i.rt;
	wb_data = '0;
	st_en   = 1'b0;
	st_addr = {ea[31:2], 2'b00};
	st_data = b;
	pc      = pc4;
	case (ins.r.opcode)
		mips_pkg::OP_RTYPE: begin
			wb_en   = (word != '0);
			wb_addr = ins.r.rd;
			case (ins.r.funct)
				mips_pkg::FN_ADDU: wb_data = a + b;
				mips_pkg::FN_SUBU: wb_data = a - b;
				mips_pkg::FN_AND:  wb_data = a & b;
				mips_pkg::FN_OR:   wb_data = a | b;
				mips_pkg::FN_XOR:  wb_data = a ^ b;
				mips_pkg::FN_NOR:  wb_data = ~(a | b);
				mips_pkg::FN_SLT:  wb_data = 32'($signed(a) < $signed(b));
				default:           wb_data = 32'(a < b);
			endcase
		end
		mips_pkg::OP_ADDIU: wb_data = ea;
		mips_pkg::OP_SLTI:  wb_data = 32'($signed(a) < $signed(sx));
		mips_pkg::OP_SLTIU: wb_data = 32'(a < sx);
		mips_pkg::OP_ANDI:  wb_data = a & zx;
		mips_pkg::OP_ORI:   wb_data = a | zx;
		mips_pkg::OP_XORI:  wb_data = a ^ zx;
		mips_pkg::OP_LUI:   wb_data = {ins.i.imm, 16'b0};
		mips_pkg::OP_LW:    wb_data = dmem[ea[5:2]];
		mips_pkg::OP_SW: begin
			wb_en          = 1'b0;
			st_en          = 1'b1;
			dmem[ea[5:2]]  = b;
		end
		mips_pkg::OP_BEQ, mips_pkg::OP_BNE: begin
			wb_en = 1'b0;
			if ((a == b) == (ins.i.opcode == mips_pkg::OP_BEQ)) begin
				pc = pc4 + {sx[29:0], 2'b00};
			end
		end
		default: begin
			wb_en = 1'b0;
			pc    = {pc4[31:28], ins.j.index, 2'b00};
		end
	endcase
	// register zero stays zero
	if (wb_en && wb_addr != '0) begin
		regs[wb_addr] = wb_data;
	end
endfunction

`endif

/* testbench/tb_mips_cpu.sv */
`default_nettype none

module tb_mips_cpu;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int PROG_WORDS     = 64;
	localparam int DATA_WORDS     = 16;
	// registers 1..31 get a value before any random instruction runs
	localparam int INIT_WORDS     = 31;
	localparam int NUM_RETIRE     = 400;
	// slowest instruction is under 20 cycles even with every delay at 3
	localparam int TIMEOUT_CYCLES = NUM_RETIRE * 20;

	logic                            clk;
	logic                            rst;
	logic [mips_pkg::WORD_W-1:0]     pc;
	logic                            inst_req_valid;
	logic                            inst_req_ready;
	logic [mips_pkg::WORD_W-1:0]     instruction;
	logic                            inst_valid;
	logic                            inst_ready;
	logic [mips_pkg::WORD_W-1:0]     address;
	logic                            mem_read;
	logic                            mem_write;
	logic [mips_pkg::WORD_W-1:0]     write_data;
	logic                            mem_req_ready;
	logic [mips_pkg::WORD_W-1:0]     read_data;
	logic                            read_data_valid;
	logic                            read_data_ready;
	logic                            rf_wen;
	logic [mips_pkg::REG_ADDR_W-1:0] rf_waddr;
	logic [mips_pkg::WORD_W-1:0]     rf_wdata;
	logic [mips_pkg::WORD_W-1:0]     retire_pc;

	integer      seed;
	// program rom and the responder's data memory
	logic [31:0] prog [PROG_WORDS];
	logic [31:0] dmem [DATA_WORDS];
	// isa model state
	logic [31:0] m_regs [32];
	logic [31:0] m_dmem [DATA_WORDS];
	logic [31:0] m_pc;

	// what the instruction in flight still owes
	bit          exp_wb_en;
	logic [4:0]  exp_wb_addr;
	logic [31:0] exp_wb_data;
	bit          exp_st_en;
	logic [31:0] exp_st_addr;
	logic [31:0] exp_st_data;
	bit          ld_pend;
	logic [31:0] cur_pc;

	// channel delay counters and outstanding responses
	int          ireq_cnt;
	int          irsp_cnt;
	int          mreq_cnt;
	int          rrsp_cnt;
	bit          irsp_pend;
	bit          rrsp_pend;
	logic [31:0] irsp_word;
	logic [31:0] rrsp_word;

	bit          started;
	bit          done;
	int          retired;
	int          cycles;
	int          mismatches;
	int          failures;

	`include "tb_mips_model.svh"

	mips_cpu mips_cpu_inst (
		.clk             (clk),
		.rst             (rst),
		.pc              (pc),
		.inst_req_valid  (inst_req_valid),
		.inst_req_ready  (inst_req_ready),
		.instruction     (instruction),
		.inst_valid      (inst_valid),
		.inst_ready      (inst_ready),
		.address         (address),
		.mem_read        (mem_read),
		.mem_write       (mem_write),
		.write_data      (write_data),
		.mem_req_ready   (mem_req_ready),
		.read_data       (read_data),
		.read_data_valid (read_data_valid),
		.read_data_ready (read_data_ready),
		.rf_wen          (rf_wen),
		.rf_waddr        (rf_waddr),
		.rf_wdata        (rf_wdata),
		.retire_pc       (retire_pc)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// 0 to 3 cycles of delay
	function automatic int rand_delay();
		return {$random(seed)} % 4;
	endfunction

	// j to its own slot or beq rs,rs to itself never leaves
	function automatic bit loops_on_itself(input mips_pkg::instr_u w, input int idx);
		bit self_j;
		bit self_beq;
		self_j   = (w.j.opcode == mips_pkg::OP_J) && (w.j.index == 26'(idx));
		self_beq = (w.i.opcode == mips_pkg::OP_BEQ) && (w.i.rs == w.i.rt) &&
		           (w.i.imm == 16'hffff);
		return self_j || self_beq;
	endfunction

	task automatic build_program();
		mips_pkg::instr_u w;
		int               i;
		// straight-line prefix, odd registers via lui and even via addiu
		for (i = 1; i < 32; i++) begin
			w          = '0;
			w.i.opcode = i[0] ? mips_pkg::OP_LUI : mips_pkg::OP_ADDIU;
			w.i.rt     = 5'(i);
			w.i.imm    = 16'($random(seed));
			prog[i-1]  = w;
		end
		for (i = INIT_WORDS; i < PROG_WORDS; i++) begin
			prog[i] = gen_instr(i, PROG_WORDS);
			while (loops_on_itself(prog[i], i)) begin
				prog[i] = gen_instr(i, PROG_WORDS);
			end
		end
	endtask

	task automatic init_memories();
		int k;
		// fill word follows the whole word index
		for (k = 0; k < DATA_WORDS; k++) begin
			dmem[k]   = 32'hc0de_0000 + 32'(k) * 32'h0001_0101;
			m_dmem[k] = dmem[k];
		end
		for (k = 0; k < 32; k++) begin
			m_regs[k] = '0;
		end
		m_pc = '0;
	endtask

	task automatic report_failure(input string msg);
		failures = failures + 1;
		$display("ERROR at %0t: %s", $time, msg);
	endtask

	task automatic check_pc(input string name, input logic [mips_pkg::WORD_W-1:0] got,
			input logic [mips_pkg::WORD_W-1:0] expected);
		if (got !== expected) begin
			mismatches = mismatches + 1;
			$display("MISMATCH %s: got %h expected %h", name, got, expected);
		end
	endtask

	task automatic check_wb(input logic [mips_pkg::REG_ADDR_W-1:0] got_addr,
			input logic [mips_pkg::REG_ADDR_W-1:0] exp_addr,
			input logic [mips_pkg::WORD_W-1:0] got_data,
			input logic [mips_pkg::WORD_W-1:0] exp_data);
		if (got_addr !== exp_addr) begin
			mismatches = mismatches + 1;
			$display("MISMATCH rf_waddr: got %h expected %h", got_addr, exp_addr);
		end
		if (got_data !== exp_data) begin
			mismatches = mismatches + 1;
			$display("MISMATCH rf_wdata: got %h expected %h", got_data, exp_data);
		end
	endtask

	task automatic check_store(input logic [mips_pkg::WORD_W-1:0] got_addr,
			input logic [mips_pkg::WORD_W-1:0] exp_addr,
			input logic [mips_pkg::WORD_W-1:0] got_data,
			input logic [mips_pkg::WORD_W-1:0] exp_data);
		if (got_addr !== exp_addr) begin
			mismatches = mismatches + 1;
			$display("MISMATCH address: got %h expected %h", got_addr, exp_addr);
		end
		if (got_data !== exp_data) begin
			mismatches = mismatches + 1;
			$display("MISMATCH write_data: got %h expected %h", got_data, exp_data);
		end
	endtask

	// a new fetch closes the previous instruction
	task automatic take_fetch();
		logic [31:0] word;
		if (started) begin
			if (exp_wb_en) begin
				report_failure($sformatf("instruction at %h ended without its write-back", cur_pc));
			end
			if (exp_st_en) begin
				report_failure($sformatf("instruction at %h ended without its store", cur_pc));
			end
			if (ld_pend) begin
				report_failure($sformatf("instruction at %h ended without its load", cur_pc));
			end
			retired = retired + 1;
		end
		check_pc("pc", pc, m_pc);
		if (retired == NUM_RETIRE) begin
			done = 1'b1;
		end else begin
			word      = prog[pc[7:2]];
			started   = 1'b1;
			cur_pc    = m_pc;
			ld_pend   = (word[31:26] == mips_pkg::OP_LW);
			irsp_word = word;
			irsp_pend = 1'b1;
			irsp_cnt  = rand_delay();
			model_step(m_regs, m_dmem, word, m_pc, exp_wb_en, exp_wb_addr, exp_wb_data,
				exp_st_en, exp_st_addr, exp_st_data);
		end
	endtask

	task automatic serve_mem_request();
		if (mem_write) begin
			if (!exp_st_en) begin
				report_failure("store request with no store instruction outstanding");
			end else begin
				check_store(address, exp_st_addr, write_data, exp_st_data);
			end
			exp_st_en          = 1'b0;
			dmem[address[5:2]] = write_data;
		end
		if (mem_read) begin
			if (!ld_pend) begin
				report_failure("load request with no load instruction outstanding");
			end else begin
				// the model gives the aligned effective address for loads too
				check_pc("address", address, exp_st_addr);
			end
			ld_pend   = 1'b0;
			rrsp_word = dmem[address[5:2]];
			rrsp_pend = 1'b1;
			rrsp_cnt  = rand_delay();
		end
	endtask

	task automatic record_write_back();
		if (!exp_wb_en) begin
			report_failure("write-back from an instruction that writes no register");
		end else begin
			check_wb(rf_waddr, exp_wb_addr, rf_wdata, exp_wb_data);
			check_pc("retire_pc", retire_pc, cur_pc);
		end
		exp_wb_en = 1'b0;
	endtask

	// mid-cycle, every handshake for the coming edge is already settled
	task automatic service_channels();
		bit ireq_fire;
		bit irsp_fire;
		bit mreq_fire;
		bit rrsp_fire;
		ireq_fire = inst_req_valid && inst_req_ready;
		irsp_fire = inst_valid && inst_ready;
		mreq_fire = (mem_read || mem_write) && mem_req_ready;
		rrsp_fire = read_data_valid && read_data_ready;
		if (!started && (mem_read || mem_write || rf_wen)) begin
			report_failure("memory strobe or write-back before the first instruction");
		end
		if (rf_wen) begin
			record_write_back();
		end
		// response counters only run while data is outstanding
		if (irsp_fire) begin
			irsp_pend = 1'b0;
		end else if (irsp_pend && irsp_cnt != 0) begin
			irsp_cnt = irsp_cnt - 1;
		end
		if (rrsp_fire) begin
			rrsp_pend = 1'b0;
		end else if (rrsp_pend && rrsp_cnt != 0) begin
			rrsp_cnt = rrsp_cnt - 1;
		end
		// ready counters only run while a request waits
		if (mreq_fire) begin
			serve_mem_request();
			mreq_cnt = rand_delay();
		end else if ((mem_read || mem_write) && mreq_cnt != 0) begin
			mreq_cnt = mreq_cnt - 1;
		end
		if (ireq_fire) begin
			take_fetch();
			ireq_cnt = rand_delay();
		end else if (inst_req_valid && ireq_cnt != 0) begin
			ireq_cnt = ireq_cnt - 1;
		end
	endtask

	task automatic drive_inputs();
		inst_req_ready  = (ireq_cnt == 0);
		inst_valid      = irsp_pend && (irsp_cnt == 0);
		instruction     = irsp_word;
		mem_req_ready   = (mreq_cnt == 0);
		read_data_valid = rrsp_pend && (rrsp_cnt == 0);
		read_data       = rrsp_word;
	endtask

	initial begin : stimulus
		seed       = 7;
		rst        = 1'b1;
		ireq_cnt   = 0;
		irsp_cnt   = 0;
		mreq_cnt   = 0;
		rrsp_cnt   = 0;
		irsp_pend  = 1'b0;
		rrsp_pend  = 1'b0;
		irsp_word  = '0;
		rrsp_word  = '0;
		exp_wb_en  = 1'b0;
		exp_st_en  = 1'b0;
		ld_pend    = 1'b0;
		cur_pc     = '0;
		started    = 1'b0;
		done       = 1'b0;
		retired    = 0;
		mismatches = 0;
		failures   = 0;
		inst_req_ready  = 1'b0;
		inst_valid      = 1'b0;
		instruction     = '0;
		mem_req_ready   = 1'b0;
		read_data_valid = 1'b0;
		read_data       = '0;
		build_program();
		init_memories();
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		drive_inputs();
		while (!done) begin
			@(negedge clk);
			service_channels();
			@(posedge clk);
			#1;
			drive_inputs();
		end
		$display("retired %0d, errors: %0d mismatches, %0d other failures",
			retired, mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	initial begin : watchdog
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles = cycles + 1;
		end
		$display("timeout: cpu stalled, %0d of %0d instructions retired in %0d cycles",
			retired, NUM_RETIRE, cycles);
		$display("retired %0d, errors: %0d mismatches, %0d other failures",
			retired, mismatches, failures + 1);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* mips_cpu.f */
+incdir+include
hw/mips_pkg.sv
hw/mips_alu.sv
hw/reg_file.sv
hw/inst_decoder.sv
hw/multicycle_fsm.sv
hw/mips_cpu.sv
testbench/tb_mips_cpu.sv

/* Makefile */
# verilator build and run of the cpu testbench
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_mips_cpu \
		-f mips_cpu.f --Mdir obj_dir -o tb_mips_cpu
	@out="$$(./obj_dir/tb_mips_cpu)"; echo "$$out"; \
		echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf obj_dir
